// ==== ahb_mem_pkg.sv ====
// AHB memory shared definitions
package ahb_mem_pkg;

  // Bus widths of the 64-bit AHB-Lite port
  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;

  // HTRANS encodings
  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,
    HTRANS_BUSY   = 2'b01,
    HTRANS_NONSEQ = 2'b10,
    HTRANS_SEQ    = 2'b11
  } htrans_e;

  // HSIZE encodings
  // Anything above a doubleword is handled as a doubleword by the slave
  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HALF  = 3'b001,
    HSIZE_WORD  = 3'b010,
    HSIZE_DWORD = 3'b011
  } hsize_e;

  // AHB-Lite uses a one-bit HRESP
  localparam logic RESP_OKAY  = 1'b0;
  localparam logic RESP_ERROR = 1'b1;

endpackage

// ==== mem_port_if.sv ====
// Memory port interface
`timescale 1ns/1ps

interface mem_port_if
  import ahb_mem_pkg::*;
#(
  parameter int MEM_WORDS = 256
) ();

  // Word index width follows the memory depth
  localparam int ADDR_BITS = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic                 we;
  logic [ADDR_BITS-1:0] addr;
  logic [STRB_W-1:0]    be;
  logic [DATA_W-1:0]    wdata;
  logic [DATA_W-1:0]    rdata;

  // Bus controller side
  modport ctrl (
    output we,
    output addr,
    output be,
    output wdata,
    input  rdata
  );

  // Memory array side
  modport mem (
    input  we,
    input  addr,
    input  be,
    input  wdata,
    output rdata
  );

endinterface

// ==== ahb_slave_ctrl.sv ====
// AHB-Lite slave controller
`timescale 1ns/1ps

module ahb_slave_ctrl
  import ahb_mem_pkg::*;
#(
  parameter int MEM_WORDS  = 256,
  parameter int INSTR_WAIT = 1,
  parameter int DATA_WAIT  = 2
) (
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              HSEL,
  input  logic [ADDR_W-1:0] HADDR,
  input  htrans_e           HTRANS,
  input  logic              HWRITE,
  input  hsize_e            HSIZE,
  input  logic [3:0]        HPROT,
  input  logic [DATA_W-1:0] HWDATA,
  input  logic              HREADY,
  output logic              HREADYOUT,
  output logic              HRESP,
  output logic [DATA_W-1:0] HRDATA,
  mem_port_if.ctrl          mem
);

  // Word index width follows the same rule as the memory port
  localparam int WORD_AW  = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int MAX_WAIT = (INSTR_WAIT > DATA_WAIT) ? INSTR_WAIT : DATA_WAIT;
  localparam int WAIT_W   = (MAX_WAIT > 0) ? $clog2(MAX_WAIT + 1) : 1;
  localparam int HWORD_W  = ADDR_W - 3;

  // The ERROR response always takes two cycles
  typedef enum logic {
    ERR_FIRST  = 1'b0,
    ERR_SECOND = 1'b1
  } err_phase_e;

  logic                accept;
  logic                out_of_range;
  logic [HWORD_W-1:0]  haddr_word;
  logic [STRB_W-1:0]   strb;
  logic [WAIT_W-1:0]   sel_wait;

  logic                dp_active;
  logic                write_q;
  logic                err_q;
  logic [WAIT_W-1:0]   wait_cnt;
  err_phase_e          err_phase;
  logic [WORD_AW-1:0]  addr_q;
  logic [STRB_W-1:0]   strb_q;

  logic                err_active;
  logic                ready_out;
  logic                read_last;

  // Address phase decode

  // Only NONSEQ and SEQ carry a transfer
  assign accept = HSEL && HREADY &&
                  ((HTRANS == HTRANS_NONSEQ) || (HTRANS == HTRANS_SEQ));

  assign haddr_word   = HADDR[ADDR_W-1:3];
  assign out_of_range = (haddr_word >= HWORD_W'(MEM_WORDS));

  // Narrow sizes are aligned down to their natural group of lanes
  always_comb begin
    case (HSIZE)
      HSIZE_BYTE: strb = STRB_W'(8'h01) << HADDR[2:0];
      HSIZE_HALF: strb = STRB_W'(8'h03) << {HADDR[2:1], 1'b0};
      HSIZE_WORD: strb = STRB_W'(8'h0f) << {HADDR[2], 2'b00};
      default:    strb = {STRB_W{1'b1}};
    endcase
  end

  // HPROT[0] low marks an instruction fetch
  assign sel_wait = HPROT[0] ? WAIT_W'(DATA_WAIT) : WAIT_W'(INSTR_WAIT);

  // Data phase control state
  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_active <= 1'b0;
      write_q   <= 1'b0;
      err_q     <= 1'b0;
      wait_cnt  <= '0;
      err_phase <= ERR_FIRST;
    end else if (accept) begin
      dp_active <= 1'b1;
      write_q   <= HWRITE;
      err_q     <= out_of_range;
      // An errored transfer skips the wait states entirely
      wait_cnt  <= out_of_range ? '0 : sel_wait;
      err_phase <= ERR_FIRST;
    end else begin
      if (ready_out) begin
        dp_active <= 1'b0;
      end
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end
      if (err_active && (err_phase == ERR_FIRST)) begin
        err_phase <= ERR_SECOND;
      end
    end
  end

  // Address and lanes of the accepted transfer
  always_ff @(posedge HCLK) begin
    if (accept) begin
      addr_q <= haddr_word[WORD_AW-1:0];
      strb_q <= strb;
    end
  end

  // Response generation

  assign err_active = dp_active && err_q;

  // Low in the first ERROR cycle, otherwise low while wait states remain
  always_comb begin
    if (err_active) begin
      ready_out = (err_phase == ERR_SECOND);
    end else begin
      ready_out = (wait_cnt == '0);
    end
  end

  assign HREADYOUT = ready_out;
  assign HRESP     = err_active ? RESP_ERROR : RESP_OKAY;

  // Read data is only presented in the cycle that completes a good read
  assign read_last = dp_active && !write_q && !err_q && ready_out;
  assign HRDATA    = read_last ? mem.rdata : '0;

  // Memory port
  // The write lands at the edge that closes the data phase
  assign mem.we    = dp_active && write_q && !err_q && ready_out;
  assign mem.addr  = addr_q;
  assign mem.be    = strb_q;
  assign mem.wdata = HWDATA;

  // Checks

  // Once ERROR is raised it has to stay for the second response cycle
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(HRESP) |=> (HRESP == RESP_ERROR))
    else $error("HRESP ERROR lasted only one cycle");

  // An out-of-range transfer must never reach the memory in either response cycle
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    ($past(accept && out_of_range) || $past(accept && out_of_range, 2)) |-> !mem.we)
    else $error("memory write during an errored transfer");

  // Wait states only run inside an in-range data phase
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    (wait_cnt != '0) |-> (dp_active && !err_q))
    else $error("wait counter running outside an in-range data phase");

endmodule

// ==== sram_bank.sv ====
// Byte-writable SRAM bank
`timescale 1ns/1ps

module sram_bank
  import ahb_mem_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic     HCLK,
  mem_port_if.mem  mem
);

  // Array of 64-bit words
  logic [DATA_W-1:0] ram [MEM_WORDS];

  // Only lanes with their enable set are updated
  always_ff @(posedge HCLK) begin
    if (mem.we) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (mem.be[i]) begin
          ram[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
        end
      end
    end
  end

  // Asynchronous read of the addressed word
  assign mem.rdata = ram[mem.addr];

  // The controller range check must keep writes inside the array
  assert property (@(posedge HCLK)
    mem.we |-> (int'(mem.addr) < MEM_WORDS))
    else $error("write to word %0d beyond the memory", mem.addr);

endmodule

// ==== ahb_mem_top.sv ====
// AHB-Lite memory subsystem
`timescale 1ns/1ps

module ahb_mem_top
  import ahb_mem_pkg::*;
#(
  parameter int MEM_WORDS  = 256,
  parameter int INSTR_WAIT = 1,
  parameter int DATA_WAIT  = 2
) (
  input  logic              HCLK,
  input  logic              HRESETn,
  input  logic              HSEL,
  input  logic [ADDR_W-1:0] HADDR,
  input  htrans_e           HTRANS,
  input  logic              HWRITE,
  input  hsize_e            HSIZE,
  // Bursts are handled beat by beat, so HBURST carries no information here
  input  logic [2:0]        HBURST,
  input  logic [3:0]        HPROT,
  input  logic [DATA_W-1:0] HWDATA,
  input  logic              HREADY,
  output logic              HREADYOUT,
  output logic              HRESP,
  output logic [DATA_W-1:0] HRDATA
);

  // Link between the bus controller and the array
  mem_port_if #(
    .MEM_WORDS (MEM_WORDS)
  ) i_mem_port ();

  ahb_slave_ctrl #(
    .MEM_WORDS  (MEM_WORDS),
    .INSTR_WAIT (INSTR_WAIT),
    .DATA_WAIT  (DATA_WAIT)
  ) i_ahb_slave_ctrl (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HPROT     (HPROT),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .HRDATA    (HRDATA),
    .mem       (i_mem_port.ctrl)
  );

  sram_bank #(
    .MEM_WORDS (MEM_WORDS)
  ) i_sram_bank (
    .HCLK (HCLK),
    .mem  (i_mem_port.mem)
  );

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 10
) (
  output logic HCLK,
  output logic HRESETn
);

  initial begin
    HCLK = 1'b0;
    forever #(PERIOD / 2) HCLK = ~HCLK;
  end

  // Reset is released on a falling edge, away from the sampling edge
  initial begin
    HRESETn = 1'b0;
    repeat (RESET_CYCLES) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
  end

endmodule

// ==== tb_ahb_mem.sv ====
// AHB memory testbench
`timescale 1ns/1ps

module tb_ahb_mem
  import ahb_mem_pkg::*;
();

  localparam int MEM_WORDS    = 256;
  localparam int INSTR_WAIT   = 1;
  localparam int DATA_WAIT    = 2;
  localparam int WAIT_LIMIT   = 16;
  localparam int RESET_LIMIT  = 100;
  localparam int RANDOM_COUNT = 40;

  // Where the expected read data of a row comes from
  localparam logic [1:0] EXP_NONE = 2'd0;
  localparam logic [1:0] EXP_REF  = 2'd1;
  localparam logic [1:0] EXP_ZERO = 2'd2;

  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [2:0]        size;
    logic              prot0;
    logic [DATA_W-1:0] wdata;
    logic [1:0]        exp_src;
  } row_t;

  logic              HCLK;
  logic              HRESETn;
  logic              HSEL;
  logic [ADDR_W-1:0] HADDR;
  htrans_e           HTRANS;
  logic              HWRITE;
  hsize_e            HSIZE;
  logic [2:0]        HBURST;
  logic [3:0]        HPROT;
  logic [DATA_W-1:0] HWDATA;
  logic              HREADY;
  logic              HREADYOUT;
  logic              HRESP;
  logic [DATA_W-1:0] HRDATA;

  row_t        rows[$];
  logic [7:0]  ref_mem [MEM_WORDS * 8];
  int          check_count;
  int          error_count;
  int          timeout_count;
  integer      seed;

  tb_clock_gen #(
    .PERIOD       (40),
    .RESET_CYCLES (10)
  ) i_tb_clock_gen (
    .HCLK    (HCLK),
    .HRESETn (HRESETn)
  );

  ahb_mem_top #(
    .MEM_WORDS  (MEM_WORDS),
    .INSTR_WAIT (INSTR_WAIT),
    .DATA_WAIT  (DATA_WAIT)
  ) i_ahb_mem_top (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HSEL      (HSEL),
    .HADDR     (HADDR),
    .HTRANS    (HTRANS),
    .HWRITE    (HWRITE),
    .HSIZE     (HSIZE),
    .HBURST    (HBURST),
    .HPROT     (HPROT),
    .HWDATA    (HWDATA),
    .HREADY    (HREADY),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .HRDATA    (HRDATA)
  );

  // Single master on the bus
  assign HREADY = HREADYOUT;

  task automatic add_row(input logic write, input logic [ADDR_W-1:0] addr,
                         input logic [2:0] size, input logic prot0,
                         input logic [DATA_W-1:0] wdata, input logic [1:0] exp_src);
    row_t r;
    r.write   = write;
    r.addr    = addr;
    r.size    = size;
    r.prot0   = prot0;
    r.wdata   = wdata;
    r.exp_src = exp_src;
    rows.push_back(r);
  endtask

  // A transfer covers 2**size bytes from its address rounded down to that size
  task automatic update_ref(input logic [ADDR_W-1:0] addr, input logic [2:0] size,
                            input logic [DATA_W-1:0] wdata);
    int unsigned nbytes;
    int unsigned first;
    int unsigned base;
    nbytes = (size > 3'd3) ? 8 : (1 << size);
    first  = 32'(addr[2:0]);
    first  = first - (first % nbytes);
    base   = (addr >> 3) * 8;
    for (int i = 0; i < nbytes; i++) begin
      ref_mem[base + first + i] = wdata[8 * (first + i) +: 8];
    end
  endtask

  function automatic logic [DATA_W-1:0] ref_word(input int unsigned word_idx);
    logic [DATA_W-1:0] data;
    for (int i = 0; i < 8; i++) begin
      data[8 * i +: 8] = ref_mem[word_idx * 8 + i];
    end
    return data;
  endfunction

  // Address phase on the current falling edge, then the whole data phase.
  // Returns in the final data cycle so the next address phase overlaps it
  task automatic run_transfer(input row_t r);
    int unsigned       word_idx;
    logic              in_range;
    int                exp_wait;
    int                low_cycles;
    logic              exp_resp;
    logic [DATA_W-1:0] exp_data;
    word_idx = r.addr >> 3;
    in_range = (word_idx < MEM_WORDS);
    exp_wait = !in_range ? 1 : (r.prot0 ? DATA_WAIT : INSTR_WAIT);
    exp_resp = in_range ? RESP_OKAY : RESP_ERROR;
    HSEL   = 1'b1;
    HADDR  = r.addr;
    HTRANS = HTRANS_NONSEQ;
    HWRITE = r.write;
    HSIZE  = hsize_e'(r.size);
    HPROT  = {3'b001, r.prot0};
    @(negedge HCLK);
    HSEL   = 1'b0;
    HTRANS = HTRANS_IDLE;
    HWDATA = r.wdata;
    low_cycles = 0;
    while (!HREADYOUT && (low_cycles < WAIT_LIMIT)) begin
      check_count++;
      if ((HRESP !== exp_resp) || (HRDATA !== '0)) begin
        error_count++;
        $display("mismatch at %0t: wait cycle of 0x%h has HRESP %b and HRDATA 0x%h",
                 $time, r.addr, HRESP, HRDATA);
      end
      low_cycles++;
      @(negedge HCLK);
    end
    if (!HREADYOUT) begin
      timeout_count++;
      $display("timeout: HREADYOUT stayed low for %0d cycles on the transfer to 0x%h",
               WAIT_LIMIT, r.addr);
    end else begin
      if (r.write || (r.exp_src == EXP_ZERO)) begin
        exp_data = '0;
      end else begin
        exp_data = ref_word(word_idx);
      end
      check_count++;
      if (low_cycles != exp_wait) begin
        error_count++;
        $display("mismatch at %0t: 0x%h took %0d wait cycles, expected %0d",
                 $time, r.addr, low_cycles, exp_wait);
      end
      check_count++;
      if (HRESP !== exp_resp) begin
        error_count++;
        $display("mismatch at %0t: 0x%h ended with HRESP %b, expected %b",
                 $time, r.addr, HRESP, exp_resp);
      end
      check_count++;
      if (HRDATA !== exp_data) begin
        error_count++;
        $display("mismatch at %0t: 0x%h returned 0x%h, expected 0x%h",
                 $time, r.addr, HRDATA, exp_data);
      end
      // The bytes land at the edge that closes this cycle
      if (r.write && in_range) begin
        update_ref(r.addr, r.size, r.wdata);
      end
    end
  endtask

  initial begin
    int unsigned pick_word;
    int unsigned pick_size;
    int unsigned pick_off;
    logic        pick_write;
    int          reset_wait;
    HSEL          = 1'b0;
    HADDR         = '0;
    HTRANS        = HTRANS_IDLE;
    HWRITE        = 1'b0;
    HSIZE         = HSIZE_BYTE;
    HBURST        = 3'b000;
    HPROT         = 4'b0011;
    HWDATA        = '0;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    seed          = 32'hbea3c357;

    // Clear the whole array so unwritten bytes read as zero
    for (int w = 0; w < MEM_WORDS; w++) begin
      add_row(1'b1, ADDR_W'(w * 8), 3'd3, 1'b1, '0, EXP_NONE);
    end
    // Doubleword round trip as a data access and as a fetch
    add_row(1'b1, 32'h0000_0000, 3'd3, 1'b1, 64'h0123_4567_89ab_cdef, EXP_NONE);
    add_row(1'b0, 32'h0000_0000, 3'd3, 1'b1, '0, EXP_REF);
    add_row(1'b0, 32'h0000_0000, 3'd3, 1'b0, '0, EXP_REF);
    // Byte, halfword and word writes at every legal offset with a read after each
    for (int sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 8; off += (1 << sz)) begin
        add_row(1'b1, ADDR_W'(8 * (sz + 1) + off), 3'(sz), 1'b1,
                {8{8'(8'h11 * (off + 1))}}, EXP_NONE);
        add_row(1'b0, ADDR_W'(8 * (sz + 1)), 3'd3, 1'((off >> sz) & 1), '0, EXP_REF);
      end
    end
    // Out-of-range transfers must leave the array alone
    add_row(1'b1, ADDR_W'(MEM_WORDS * 8), 3'd3, 1'b1, 64'hdead_beef_dead_beef, EXP_NONE);
    add_row(1'b0, ADDR_W'(MEM_WORDS * 8), 3'd3, 1'b1, '0, EXP_ZERO);
    add_row(1'b1, 32'h0000_ffff, 3'd0, 1'b0, 64'hffff_ffff_ffff_ffff, EXP_NONE);
    add_row(1'b0, 32'hffff_fff8, 3'd3, 1'b0, '0, EXP_ZERO);
    for (int w = 0; w < MEM_WORDS; w++) begin
      add_row(1'b0, ADDR_W'(w * 8), 3'd3, 1'(w & 1), '0, EXP_REF);
    end
    // Random mix reaching a few words past the end
    for (int n = 0; n < RANDOM_COUNT; n++) begin
      pick_word  = $unsigned($random(seed)) % (MEM_WORDS + 4);
      pick_size  = $unsigned($random(seed)) % 4;
      pick_off   = $unsigned($random(seed)) % 8;
      pick_off   = pick_off - (pick_off % (1 << pick_size));
      pick_write = 1'($random(seed) & 1);
      add_row(pick_write, ADDR_W'(pick_word * 8 + pick_off), 3'(pick_size),
              1'($random(seed) & 1), {$random(seed), $random(seed)},
              pick_write ? EXP_NONE : ((pick_word < MEM_WORDS) ? EXP_REF : EXP_ZERO));
    end

    reset_wait = 0;
    while ((HRESETn !== 1'b1) && (reset_wait < RESET_LIMIT)) begin
      reset_wait++;
      @(negedge HCLK);
    end
    if (HRESETn !== 1'b1) begin
      timeout_count++;
      $display("timeout: reset was still asserted after %0d cycles", RESET_LIMIT);
    end else begin
      @(negedge HCLK);
      check_count++;
      if ((HREADYOUT !== 1'b1) || (HRESP !== RESP_OKAY) || (HRDATA !== '0)) begin
        error_count++;
        $display("mismatch at %0t: after reset HREADYOUT %b, HRESP %b, HRDATA 0x%h",
                 $time, HREADYOUT, HRESP, HRDATA);
      end
      foreach (rows[i]) begin
        run_transfer(rows[i]);
      end
    end

    $display("checks: %0d, mismatches: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if ((error_count == 0) && (timeout_count == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
ahb_mem_pkg.sv
mem_port_if.sv
ahb_slave_ctrl.sv
sram_bank.sv
ahb_mem_top.sv
tb_clock_gen.sv
tb_ahb_mem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the AHB memory testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_ahb_mem \
  --Mdir obj_dir \
  -f verilog.f

./obj_dir/Vtb_ahb_mem | tee sim.log

# The testbench prints its failure line on any error or timeout
if grep -q "Test failed" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation passed"
